// File: design/fetch_pkg.sv
/*
 fetch front end types
 address, instruction, control bus and fetch state encoding
 */
`include "fetch_settings.svh"

package fetch_pkg;

    // fetch address
    typedef logic [`XLEN-1:0] addr_t;

    // raw 32-bit instruction word
    typedef logic [`ILEN-1:0] inst_t;

    // stall and flush bus, indexed by the CU_* bit positions
    typedef logic [`CU_BUS_WIDTH-1:0] cu_bus_t;

    // wishbone fetch state machine
    // idle   no cycle on the bus
    // busy   read in flight, response kept
    // drop   read in flight, response stale after a flush
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_BUSY = 2'd1,
        FETCH_DROP = 2'd2
    } fetch_state_e;

endpackage

// File: design/fetch_settings.svh
/*
 fetch front end settings
 widths, reset pc, queue depth and control bus bit positions
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// fetch address and instruction widths
`define XLEN 32
`define ILEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// instruction queue entries, power of two
`define IQ_DEPTH 4

// control bus layout, one bit per stage request
`define CU_BUS_WIDTH 4
`define CU_STALL_IF 0
`define CU_STALL_ID 1
`define CU_FLUSH 2
`define CU_STALL_DISPATCH 3

`endif

// File: design/fetch_top.sv
/*
 instruction fetch front end
 pc, wishbone fetch fsm, instruction queue and pipeline control
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_top (
    input  logic               clk,
    input  logic               rst_n_i,
    // execute stage
    input  logic               jump_flag_i,
    input  fetch_pkg::addr_t   jump_addr_i,
    input  logic               stall_ex_i,
    // hazard unit
    input  logic               stall_hdu_i,
    // interrupt controller
    input  logic               flush_clint_i,
    input  fetch_pkg::addr_t   trap_addr_i,
    // wishbone classic master
    input  fetch_pkg::inst_t   wb_dat_i,
    input  logic               wb_ack_i,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic               wb_we_o,
    output logic [`ILEN/8-1:0] wb_sel_o,
    output fetch_pkg::addr_t   wb_adr_o,
    // dispatch
    input  logic               dispatch_ready_i,
    output logic               inst_valid_o,
    output fetch_pkg::addr_t   inst_pc_o,
    output fetch_pkg::inst_t   inst_o,
    // decode
    output logic               stall_id_o
);

    fetch_pkg::cu_bus_t stall_bus;
    logic               redirect;
    fetch_pkg::addr_t   redirect_addr;
    logic               iq_full;
    fetch_pkg::addr_t   pc;
    logic               fetch_accept;
    fetch_pkg::addr_t   accept_pc;
    fetch_pkg::inst_t   accept_inst;

    // request merge, queue full feeds back as the if stall
    pipe_ctrl u_pipe_ctrl (
        .jump_flag_i     (jump_flag_i),
        .jump_addr_i     (jump_addr_i),
        .stall_ex_i      (stall_ex_i),
        .stall_hdu_i     (stall_hdu_i),
        .flush_clint_i   (flush_clint_i),
        .trap_addr_i     (trap_addr_i),
        .stall_iq_i      (iq_full),
        .stall_bus_o     (stall_bus),
        .redirect_o      (redirect),
        .redirect_addr_o (redirect_addr)
    );

    // pc steps once per kept response
    pc_reg u_pc_reg (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .advance_i       (fetch_accept),
        .pc_o            (pc)
    );

    ifetch_wb_fsm u_ifetch_wb_fsm (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_bus_i   (stall_bus),
        .pc_i          (pc),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_we_o       (wb_we_o),
        .wb_sel_o      (wb_sel_o),
        .wb_adr_o      (wb_adr_o),
        .accept_o      (fetch_accept),
        .accept_pc_o   (accept_pc),
        .accept_inst_o (accept_inst)
    );

    // same accept pulse pushes the pair
    inst_queue u_inst_queue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_bus_i (stall_bus),
        .push_i      (fetch_accept),
        .push_pc_i   (accept_pc),
        .push_inst_i (accept_inst),
        .ready_i     (dispatch_ready_i),
        .full_o      (iq_full),
        .valid_o     (inst_valid_o),
        .pc_o        (inst_pc_o),
        .inst_o      (inst_o)
    );

    assign stall_id_o = stall_bus[`CU_STALL_ID];

endmodule

// File: design/ifetch_wb_fsm.sv
/*
 instruction fetch master
 wishbone classic reads, one in flight, stale responses dropped
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module ifetch_wb_fsm (
    input  logic                 clk,
    input  logic                 rst_n_i,
    // control bus, uses the if stall and flush bits
    input  fetch_pkg::cu_bus_t   stall_bus_i,
    // address to fetch next
    input  fetch_pkg::addr_t     pc_i,
    // wishbone classic master
    input  fetch_pkg::inst_t     wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output logic [`ILEN/8-1:0]   wb_sel_o,
    output fetch_pkg::addr_t     wb_adr_o,
    // kept response toward pc and queue
    output logic                 accept_o,
    output fetch_pkg::addr_t     accept_pc_o,
    output fetch_pkg::inst_t     accept_inst_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;
    fetch_pkg::addr_t        adr_q;
    logic                    stall_if;
    logic                    flush;
    logic                    start;

    assign stall_if = stall_bus_i[`CU_STALL_IF];
    assign flush    = stall_bus_i[`CU_FLUSH];

    // open a read only with a free queue slot and no redirect pending
    assign start = (state_q == fetch_pkg::FETCH_IDLE) & ~stall_if & ~flush;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::FETCH_IDLE: begin
                if (start) begin
                    state_d = fetch_pkg::FETCH_BUSY;
                end
            end
            fetch_pkg::FETCH_BUSY: begin
                // flush with the ack just discards the data
                if (wb_ack_i) begin
                    state_d = fetch_pkg::FETCH_IDLE;
                end else if (flush) begin
                    state_d = fetch_pkg::FETCH_DROP;
                end
            end
            fetch_pkg::FETCH_DROP: begin
                // finish the stale read, bus rules forbid abandoning it
                if (wb_ack_i) begin
                    state_d = fetch_pkg::FETCH_IDLE;
                end
            end
            default: state_d = fetch_pkg::FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= fetch_pkg::FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address frozen for the whole cycle, pc may move under it
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= pc_i;
        end
    end

    // cyc and stb move together, single reads only
    assign wb_cyc_o = (state_q != fetch_pkg::FETCH_IDLE);
    assign wb_stb_o = (state_q != fetch_pkg::FETCH_IDLE);
    assign wb_we_o  = 1'b0;
    assign wb_sel_o = '1;
    assign wb_adr_o = adr_q;

    // ack outside busy is either stale or spurious
    assign accept_o      = (state_q == fetch_pkg::FETCH_BUSY) & wb_ack_i & ~flush;
    assign accept_pc_o   = adr_q;
    assign accept_inst_o = wb_dat_i;

endmodule

// File: design/inst_queue.sv
/*
 instruction queue
 ring buffer of pc and instruction pairs, valid/ready toward dispatch
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_queue (
    input  logic               clk,
    input  logic               rst_n_i,
    // control bus, uses the flush and dispatch stall bits
    input  fetch_pkg::cu_bus_t stall_bus_i,
    // write side from fetch
    input  logic               push_i,
    input  fetch_pkg::addr_t   push_pc_i,
    input  fetch_pkg::inst_t   push_inst_i,
    // read side toward dispatch
    input  logic               ready_i,
    output logic               full_o,
    output logic               valid_o,
    output fetch_pkg::addr_t   pc_o,
    output fetch_pkg::inst_t   inst_o
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);

    fetch_pkg::addr_t pc_mem   [`IQ_DEPTH];
    fetch_pkg::inst_t inst_mem [`IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             flush;
    logic             do_push;
    logic             do_pop;

    assign flush = stall_bus_i[`CU_FLUSH];

    assign valid_o = (count != '0);
    assign full_o  = (count == (PTR_W+1)'(`IQ_DEPTH));

    // transfer needs dispatch free of an execute stall
    assign do_pop  = valid_o & ready_i & ~stall_bus_i[`CU_STALL_DISPATCH];
    assign do_push = push_i & ~full_o;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave count unchanged
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    // storage only, occupancy lives in count
    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push_pc_i;
            inst_mem[wr_ptr] <= push_inst_i;
        end
    end

    // head entry, qualified by valid_o
    assign pc_o   = pc_mem[rd_ptr];
    assign inst_o = inst_mem[rd_ptr];

endmodule

// File: design/pc_reg.sv
/*
 program counter
 loads a redirect target, otherwise steps by four per accepted fetch
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_reg (
    input  logic             clk,
    input  logic             rst_n_i,
    // redirect from control unit
    input  logic             redirect_i,
    input  fetch_pkg::addr_t redirect_addr_i,
    // one pulse per kept fetch response
    input  logic             advance_i,
    // next address to fetch
    output fetch_pkg::addr_t pc_o
);

    fetch_pkg::addr_t pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (redirect_i) begin
            // redirect wins over a same-cycle advance
            pc_q <= redirect_addr_i;
        end else if (advance_i) begin
            // fixed 4-byte instructions, no compressed support
            pc_q <= pc_q + fetch_pkg::addr_t'(4);
        end
    end

    // fetch fsm samples this when it opens a bus cycle
    assign pc_o = pc_q;

endmodule

// File: design/pipe_ctrl.sv
/*
 pipeline control unit
 merges stall and flush requests, picks the redirect target
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pipe_ctrl (
    // from execute stage
    input  logic               jump_flag_i,
    input  fetch_pkg::addr_t   jump_addr_i,
    input  logic               stall_ex_i,
    // from hazard unit
    input  logic               stall_hdu_i,
    // from interrupt controller
    input  logic               flush_clint_i,
    input  fetch_pkg::addr_t   trap_addr_i,
    // from instruction queue
    input  logic               stall_iq_i,
    // stage control bus
    output fetch_pkg::cu_bus_t stall_bus_o,
    // to pc register
    output logic               redirect_o,
    output fetch_pkg::addr_t   redirect_addr_o
);

    logic jump_ok;

    // jump only counts once execute has finished the instruction
    assign jump_ok = jump_flag_i & ~stall_ex_i;

    // interrupt flush overrides any jump
    assign redirect_o      = flush_clint_i | jump_ok;
    assign redirect_addr_o = flush_clint_i ? trap_addr_i : jump_addr_i;

    // fetch stops while the queue has no free slot
    assign stall_bus_o[`CU_STALL_IF]       = stall_iq_i;
    // hazard stall is moot when a jump throws the younger ops away
    assign stall_bus_o[`CU_STALL_ID]       = stall_ex_i | (stall_hdu_i & ~jump_flag_i);
    // every redirect empties the front end
    assign stall_bus_o[`CU_FLUSH]          = redirect_o;
    // dispatch holds while execute is busy
    assign stall_bus_o[`CU_STALL_DISPATCH] = stall_ex_i;

endmodule

// File: project.f
+incdir+design
design/fetch_pkg.sv
design/pipe_ctrl.sv
design/pc_reg.sv
design/ifetch_wb_fsm.sv
design/inst_queue.sv
design/fetch_top.sv
verification/fetch_chk.sv
verification/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_tb \
    -f project.f \
    -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

// File: verification/fetch_chk.sv
/*
 fetch front end assertions
 wishbone handshake, queue occupancy and flush behaviour
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_chk (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       cyc_i,
    input logic                       stb_i,
    input logic                       ack_i,
    input fetch_pkg::addr_t           adr_i,
    input logic                       flush_i,
    input logic                       valid_i,
    input logic [$clog2(`IQ_DEPTH):0] count_i
);

    // cycle closes right after the acked transfer
    a_cyc_close: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stb_i && ack_i) |=> (!cyc_i && !stb_i))
        else $error("wishbone cycle still open after ack");

    // request held with the same address until the slave acks
    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(adr_i)))
        else $error("wishbone request dropped or address moved before ack");

    // occupancy bound
    a_count_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        count_i <= ($clog2(`IQ_DEPTH)+1)'(`IQ_DEPTH))
        else $error("instruction queue count above depth");

    // flushed queue shows nothing on the next cycle
    a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> !valid_i)
        else $error("inst_valid_o high right after a flush");

endmodule

bind fetch_top fetch_chk u_fetch_chk (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cyc_i   (wb_cyc_o),
    .stb_i   (wb_stb_o),
    .ack_i   (wb_ack_i),
    .adr_i   (wb_adr_o),
    .flush_i (stall_bus[`CU_FLUSH]),
    .valid_i (inst_valid_o),
    .count_i (u_inst_queue.count)
);

// File: verification/fetch_tb.sv
/*
 fetch front end testbench
 seeded random stimulus, wishbone slave model and reference pc model
 */
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb;

    localparam int               WAIT_LIMIT = 3000;
    localparam fetch_pkg::inst_t MEM_KEY    = 32'h5a3c_96e1;

    logic               clk;
    logic               rst_n_i;
    logic               jump_flag_i;
    fetch_pkg::addr_t   jump_addr_i;
    logic               stall_ex_i;
    logic               stall_hdu_i;
    logic               flush_clint_i;
    fetch_pkg::addr_t   trap_addr_i;
    fetch_pkg::inst_t   wb_dat_i;
    logic               wb_ack_i;
    logic               wb_cyc_o;
    logic               wb_stb_o;
    logic               wb_we_o;
    logic [`ILEN/8-1:0] wb_sel_o;
    fetch_pkg::addr_t   wb_adr_o;
    logic               dispatch_ready_i;
    logic               inst_valid_o;
    fetch_pkg::addr_t   inst_pc_o;
    fetch_pkg::inst_t   inst_o;
    logic               stall_id_o;

    integer seed;
    // stimulus knobs as 1-in-N rates where 0 means never
    int     rate_jump;
    int     rate_clint;
    int     rate_ex;
    int     rate_hdu;
    int     rate_ready_low;
    logic   hold_ready;
    logic   hold_ex;
    logic   rst_level;
    // slave wait state tracking
    logic   slave_busy;
    int     slave_wait;
    // reference model state
    fetch_pkg::addr_t exp_pc;
    logic   prev_redir;
    int     n_xfers;
    int     n_redirects;

    fetch_top u_fetch_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory image where each word depends on the full address
    function automatic fetch_pkg::inst_t mem_word(fetch_pkg::addr_t addr);
        fetch_pkg::inst_t x;
        x = fetch_pkg::inst_t'(addr) ^ MEM_KEY;
        return (x << 7) | (x >> (`ILEN - 7));
    endfunction

    function automatic logic chance(int n);
        if (n == 0) begin
            return 1'b0;
        end
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    // word aligned target
    function automatic fetch_pkg::addr_t rand_addr();
        return fetch_pkg::addr_t'($random(seed)) & ~fetch_pkg::addr_t'(3);
    endfunction

    task automatic check_addr(string name, fetch_pkg::addr_t got, fetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_inst(string name, fetch_pkg::inst_t got, fetch_pkg::inst_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic stop_on_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "wait limit reached");
    endtask

    // slave acks after 0 to 3 wait states and drives garbage data otherwise
    task automatic drive_slave();
        wb_dat_i = fetch_pkg::inst_t'($random(seed));
        if (wb_ack_i) begin
            // ack consumed at this edge
            wb_ack_i = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!slave_busy) begin
                slave_busy = 1'b1;
                slave_wait = $unsigned($random(seed)) % 4;
            end
            if (slave_wait == 0) begin
                wb_ack_i   = 1'b1;
                wb_dat_i   = mem_word(wb_adr_o);
                slave_busy = 1'b0;
            end else begin
                slave_wait = slave_wait - 1;
            end
        end
    endtask

    task automatic drive_inputs();
        rst_n_i          = rst_level;
        flush_clint_i    = chance(rate_clint);
        // traps often collide with a jump
        jump_flag_i      = chance(rate_jump) | (flush_clint_i & chance(2));
        jump_addr_i      = rand_addr();
        trap_addr_i      = rand_addr();
        stall_ex_i       = hold_ex | chance(rate_ex);
        stall_hdu_i      = chance(rate_hdu);
        dispatch_ready_i = ~hold_ready & ~chance(rate_ready_low);
    endtask

    // runs at the falling edge and predicts the next rising edge
    task automatic model_cycle();
        logic             redir;
        logic             xfer;
        fetch_pkg::addr_t target;
        if (!rst_n_i) begin
            return;
        end
        check_bit("stall_id_o", stall_id_o, stall_ex_i | (stall_hdu_i & ~jump_flag_i));
        if (prev_redir) begin
            check_bit("inst_valid_o", inst_valid_o, 1'b0);
        end
        redir  = flush_clint_i | (jump_flag_i & ~stall_ex_i);
        target = flush_clint_i ? trap_addr_i : jump_addr_i;
        xfer   = inst_valid_o & dispatch_ready_i & ~stall_ex_i;
        // the head entry still transfers on a redirect edge
        if (xfer) begin
            check_addr("inst_pc_o", inst_pc_o, exp_pc);
            check_inst("inst_o", inst_o, mem_word(exp_pc));
            exp_pc = exp_pc + 4;
            n_xfers++;
        end
        // a redirect empties the queue and restarts at the target
        if (redir) begin
            exp_pc = target;
            n_redirects++;
        end
        prev_redir = redir;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
        drive_slave();
        drive_inputs();
        @(negedge clk);
        model_cycle();
    endtask

    task automatic wait_events(int xfers, int redirects, string what);
        int xfer_goal;
        int redir_goal;
        int cycles;
        xfer_goal  = n_xfers + xfers;
        redir_goal = n_redirects + redirects;
        cycles     = 0;
        while (n_xfers < xfer_goal || n_redirects < redir_goal) begin
            if (cycles >= WAIT_LIMIT) begin
                stop_on_timeout(what);
            end
            step_cycle();
            cycles++;
        end
    endtask

    task automatic check_idle_outputs();
        check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
        check_bit("wb_stb_o", wb_stb_o, 1'b0);
        check_bit("inst_valid_o", inst_valid_o, 1'b0);
        check_bit("stall_id_o", stall_id_o, 1'b0);
    endtask

    initial begin
        int cycles;
        seed             = 32'hed835acf;
        rst_n_i          = 1'b0;
        jump_flag_i      = 1'b0;
        jump_addr_i      = '0;
        stall_ex_i       = 1'b0;
        stall_hdu_i      = 1'b0;
        flush_clint_i    = 1'b0;
        trap_addr_i      = '0;
        wb_dat_i         = '0;
        wb_ack_i         = 1'b0;
        dispatch_ready_i = 1'b0;
        rate_jump        = 0;
        rate_clint       = 0;
        rate_ex          = 0;
        rate_hdu         = 0;
        rate_ready_low   = 0;
        hold_ready       = 1'b0;
        hold_ex          = 1'b0;
        rst_level        = 1'b0;
        slave_busy       = 1'b0;
        slave_wait       = 0;
        exp_pc           = `RESET_PC;
        prev_redir       = 1'b0;
        n_xfers          = 0;
        n_redirects      = 0;

        repeat (10) begin
            step_cycle();
            check_idle_outputs();
        end
        // released but still idle until the next edge
        rst_level = 1'b1;
        step_cycle();
        check_idle_outputs();

        cycles = 0;
        while (!wb_cyc_o) begin
            if (cycles >= 50) begin
                stop_on_timeout("first wishbone cycle");
            end
            step_cycle();
            cycles++;
        end
        check_addr("wb_adr_o", wb_adr_o, `RESET_PC);
        check_bit("wb_we_o", wb_we_o, 1'b0);
        check_bit("wb_sel_o all ones", &wb_sel_o, 1'b1);

        // plain sequential stream with light stalls
        rate_hdu       = 3;
        rate_ready_low = 4;
        rate_ex        = 8;
        wait_events(24, 0, "sequential delivery");

        // jumps with some masked by execute stalls
        rate_jump = 8;
        wait_events(40, 8, "jump redirects");

        // traps often together with a jump
        rate_clint = 12;
        wait_events(40, 16, "interrupt redirects");

        // long back-pressure so the queue fills and fetch stops
        rate_jump      = 0;
        rate_clint     = 0;
        rate_ex        = 0;
        rate_ready_low = 0;
        hold_ready     = 1'b1;
        repeat (40) step_cycle();
        check_bit("inst_valid_o", inst_valid_o, 1'b1);
        check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
        hold_ready = 1'b0;
        hold_ex    = 1'b1;
        repeat (20) step_cycle();
        check_bit("inst_valid_o", inst_valid_o, 1'b1);
        check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
        hold_ex = 1'b0;
        wait_events(20, 0, "delivery after back-pressure");

        $display("All checks passed");
        $finish;
    end

endmodule
